//--- hw/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Host address width in bits, one halfword per address pair
`define ADDR_W 16

// Width of one cached halfword
`define DATA_W 16

// Request id width, so up to 16 requests can be told apart
`define ID_W 4

// Number of cache banks, selected by address bits [5:4]
`define N_BANKS 4

// Entries in each bank queue, and the credit the dispatcher starts with per bank
`define QUEUE_DEPTH 2

// Response credits the collector holds after reset
`define RSP_CREDITS 4

`endif

//--- hw/cache_geom_pkg.sv
`include "cache_defines.svh"

package cache_geom_pkg;

  // Field widths of the address split, the tag takes what is left
  localparam int WORD_W = 3;
  localparam int SET_W  = 4;
  localparam int BANK_W = $clog2(`N_BANKS);
  localparam int TAG_W  = `ADDR_W - SET_W - BANK_W - WORD_W - 1;

  localparam int N_SETS  = 2 ** SET_W;   // Sets held by one bank
  localparam int N_WORDS = 2 ** WORD_W;  // Halfwords per line

  typedef struct packed {
    logic [TAG_W-1:0]  tag;       // Bits [15:10]
    logic [SET_W-1:0]  set;       // Bits [9:6], set inside the bank
    logic [BANK_W-1:0] bank;      // Bits [5:4], picks the bank
    logic [WORD_W-1:0] word;      // Bits [3:1], halfword in the line
    logic              byte_sel;  // Bit 0, ignored by the cache
  } cache_addr_t;

  // One way of one set; a set lru bit marks the next victim
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             valid;
    logic             lru;
  } tag_entry_t;

endpackage

//--- hw/cache_msg_pkg.sv
`include "cache_defines.svh"

package cache_msg_pkg;

  ///////////////////////////////////////////////////
  // Request from the host, broadcast to the banks

  typedef struct packed {
    logic                      write;  // High for a write, low for a read
    logic [`ID_W-1:0]          id;     // Echoed back in the response
    cache_geom_pkg::cache_addr_t addr; // Split halfword address
    logic [`DATA_W-1:0]        data;   // Write data, don't care on a read
  } cache_req_t;

  ///////////////////////////////////////////////////
  // Response from a bank, forwarded to the host

  typedef struct packed {
    logic               write;  // Copy of the request's write flag
    logic [`ID_W-1:0]   id;     // Id of the request being answered
    logic               hit;    // Tag matched a valid way
    logic [`DATA_W-1:0] data;   // Read hit data, zero otherwise
  } cache_rsp_t;

  // A response that carries nothing yet
  localparam cache_rsp_t RSP_IDLE = '{
    write: 1'b0,
    id:    '0,
    hit:   1'b0,
    data:  '0
  };

endpackage

//--- hw/credit_fifo.sv
`timescale 1ns/100ps

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     not_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t            mem [DEPTH];  // Storage, no reset needed
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;        // Entries currently held
  logic                do_push;
  logic                do_pop;

  assign do_push   = push && not_full;  // A push into a full queue is dropped
  assign do_pop    = pop && not_empty;
  assign not_empty = (count != '0);
  assign not_full  = (count != CNT_W'(DEPTH));
  assign pop_data  = mem[rd_ptr];       // Head is visible without a pop

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither leave the level alone
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

//--- hw/request_dispatcher.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module request_dispatcher (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_msg_pkg::cache_req_t req,
  input  logic                      req_valid,
  input  logic [`N_BANKS-1:0]       bank_credit,
  output logic                      req_ready,
  output cache_msg_pkg::cache_req_t bank_req,
  output logic [`N_BANKS-1:0]       bank_req_valid
);

  import cache_geom_pkg::*;

  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  logic [CNT_W-1:0] credit_cnt [`N_BANKS];  // Free slots in each bank's request queue
  logic             accept;                 // Request transfers this cycle

  //////////////////////////////////////////////////
  // Steering

  // Ready only looks at the bank the current address names
  assign req_ready = (credit_cnt[req.addr.bank] != '0);
  assign accept    = req_valid && req_ready;
  assign bank_req  = req;  // Every bank sees the payload, only one is strobed

  always_comb begin
    for (int i = 0; i < `N_BANKS; i++) begin
      bank_req_valid[i] = accept && (req.addr.bank == BANK_W'(i));
    end
  end

  //////////////////////////////////////////////////
  // Credit counters

  // A push spends a credit and a bank pop returns one, both may land together
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `N_BANKS; i++) begin
        credit_cnt[i] <= CNT_W'(`QUEUE_DEPTH);
      end
    end else begin
      for (int i = 0; i < `N_BANKS; i++) begin
        case ({bank_req_valid[i], bank_credit[i]})
          2'b10:   credit_cnt[i] <= credit_cnt[i] - 1'b1;
          2'b01:   credit_cnt[i] <= credit_cnt[i] + 1'b1;
          default: credit_cnt[i] <= credit_cnt[i];
        endcase
      end
    end
  end

endmodule

//--- hw/cache_bank.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_bank (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_msg_pkg::cache_req_t bank_req,
  input  logic                      bank_req_valid,
  input  logic                      rsp_pop,
  output logic                      bank_credit,
  output cache_msg_pkg::cache_rsp_t bank_rsp,
  output logic                      bank_rsp_valid
);

  import cache_geom_pkg::*;
  import cache_msg_pkg::*;

  cache_req_t         head;        // Oldest queued request
  cache_rsp_t         rsp_next;    // Response built from the head
  logic               req_avail;
  logic               rsp_room;
  logic               pop_req;     // Access is performed this cycle
  tag_entry_t         tags [N_SETS][2];
  logic [`DATA_W-1:0] data_mem [2][N_SETS][N_WORDS];
  tag_entry_t         entry [2];       // Both ways of the addressed set
  tag_entry_t         entry_next [2];  // Same ways after the access
  logic [1:0]         match;
  logic               hit;
  logic               victim;      // Way whose lru bit is set
  logic               way_sel;     // Way that is read or written
  logic               access;      // Hit or write, the lru bits move

  //////////////////////////////////////////////////
  // Queues

  credit_fifo #(.payload_t(cache_req_t), .DEPTH(`QUEUE_DEPTH)) u_req_q (
    .clk       (clk),
    .rst       (rst),
    .push      (bank_req_valid),
    .push_data (bank_req),
    .pop       (pop_req),
    .pop_data  (head),
    .not_empty (req_avail),
    .not_full  ()  // Dispatcher credits already guarantee room
  );

  credit_fifo #(.payload_t(cache_rsp_t), .DEPTH(`QUEUE_DEPTH)) u_rsp_q (
    .clk       (clk),
    .rst       (rst),
    .push      (pop_req),
    .push_data (rsp_next),
    .pop       (rsp_pop),
    .pop_data  (bank_rsp),
    .not_empty (bank_rsp_valid),
    .not_full  (rsp_room)
  );

  assign pop_req     = req_avail && rsp_room;  // A full response queue stalls the bank
  assign bank_credit = pop_req;                // Each pop frees one request slot

  //////////////////////////////////////////////////
  // Tag compare and way choice

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      entry[w] = tags[head.addr.set][w];
      match[w] = entry[w].valid && (entry[w].tag == head.addr.tag);
    end
  end

  assign hit     = |match;
  assign victim  = entry[1].lru;                 // Lru bits are always complementary
  assign way_sel = hit ? match[1] : victim;      // Hitting way, else the victim
  assign access  = hit || head.write;            // A read miss leaves the set alone

  // The accessed way becomes most recent, a write miss also installs the tag
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      entry_next[w]     = entry[w];
      entry_next[w].lru = (way_sel != 1'(w));
      if (head.write && !hit && (way_sel == 1'(w))) begin
        entry_next[w].tag   = head.addr.tag;
        entry_next[w].valid = 1'b1;
      end
    end
  end

  // After reset way 1 is the first victim
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < N_SETS; s++) begin
        for (int w = 0; w < 2; w++) begin
          tags[s][w] <= '{tag: '0, valid: 1'b0, lru: 1'(w)};
        end
      end
    end else if (pop_req && access) begin
      tags[head.addr.set][0] <= entry_next[0];
      tags[head.addr.set][1] <= entry_next[1];
    end
  end

  always_ff @(posedge clk) begin
    if (pop_req && head.write) begin
      data_mem[way_sel][head.addr.set][head.addr.word] <= head.data;
    end
  end

  // Data only goes back on a read hit
  always_comb begin
    rsp_next       = RSP_IDLE;
    rsp_next.write = head.write;
    rsp_next.id    = head.id;
    rsp_next.hit   = hit;
    if (hit && !head.write) rsp_next.data = data_mem[way_sel][head.addr.set][head.addr.word];
  end

endmodule

//--- hw/response_collector.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module response_collector (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_msg_pkg::cache_rsp_t bank_rsp [`N_BANKS],
  input  logic [`N_BANKS-1:0]       bank_rsp_valid,
  input  logic                      rsp_credit,
  output logic [`N_BANKS-1:0]       bank_rsp_pop,
  output cache_msg_pkg::cache_rsp_t rsp,
  output logic                      rsp_valid
);

  import cache_geom_pkg::*;

  localparam int CNT_W = $clog2(`RSP_CREDITS + 1);

  logic [BANK_W-1:0] last;        // Bank served most recently
  logic [BANK_W-1:0] pick;        // Next valid bank after last
  logic              found;
  logic              grant;       // Take a response this cycle
  logic [CNT_W-1:0]  credit_cnt;  // Host credits, the response on rsp still counts

  // Search starts one past the last bank served
  always_comb begin
    logic [BANK_W-1:0] idx;
    pick  = last;
    found = 1'b0;
    for (int k = 1; k <= `N_BANKS; k++) begin
      idx = BANK_W'(int'(last) + k);
      if (!found && bank_rsp_valid[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
  end

  // A response already on rsp has not been charged yet, so it is reserved here
  assign grant        = found && (credit_cnt > CNT_W'(rsp_valid));
  assign bank_rsp_pop = `N_BANKS'(grant) << pick;

  always_ff @(posedge clk) begin
    if (rst) begin
      last       <= BANK_W'(`N_BANKS - 1);  // Bank 0 goes first
      rsp_valid  <= 1'b0;
      credit_cnt <= CNT_W'(`RSP_CREDITS);
    end else begin
      rsp_valid  <= grant;
      credit_cnt <= credit_cnt + CNT_W'(rsp_credit) - CNT_W'(rsp_valid);
      if (grant) last <= pick;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) rsp <= bank_rsp[pick];  // Payload only, rsp_valid qualifies it
  end

endmodule

//--- hw/banked_cache.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module banked_cache (
  input  logic                      clk,
  input  logic                      rst,
  input  cache_msg_pkg::cache_req_t req,
  input  logic                      req_valid,
  input  logic                      rsp_credit,
  output logic                      req_ready,
  output cache_msg_pkg::cache_rsp_t rsp,
  output logic                      rsp_valid
);

  import cache_msg_pkg::*;

  cache_req_t          bank_req;                 // Broadcast to every bank
  logic [`N_BANKS-1:0] bank_req_valid;
  logic [`N_BANKS-1:0] bank_credit;
  cache_rsp_t          bank_rsp [`N_BANKS];      // Heads of the response queues
  logic [`N_BANKS-1:0] bank_rsp_valid;
  logic [`N_BANKS-1:0] bank_rsp_pop;

  request_dispatcher u_dispatch (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .req_valid      (req_valid),
    .bank_credit    (bank_credit),
    .req_ready      (req_ready),
    .bank_req       (bank_req),
    .bank_req_valid (bank_req_valid)
  );

  // One bank per value of address bits [5:4]
  for (genvar i = 0; i < `N_BANKS; i++) begin : g_bank
    cache_bank u_bank (
      .clk            (clk),
      .rst            (rst),
      .bank_req       (bank_req),
      .bank_req_valid (bank_req_valid[i]),
      .rsp_pop        (bank_rsp_pop[i]),
      .bank_credit    (bank_credit[i]),
      .bank_rsp       (bank_rsp[i]),
      .bank_rsp_valid (bank_rsp_valid[i])
    );
  end

  response_collector u_collect (
    .clk            (clk),
    .rst            (rst),
    .bank_rsp       (bank_rsp),
    .bank_rsp_valid (bank_rsp_valid),
    .rsp_credit     (rsp_credit),
    .bank_rsp_pop   (bank_rsp_pop),
    .rsp            (rsp),
    .rsp_valid      (rsp_valid)
  );

endmodule

//--- test/banked_cache_assertions.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module banked_cache_assertions (
  input logic                               clk,
  input logic                               rst,
  input logic [cache_geom_pkg::BANK_W-1:0]  req_bank,
  input logic                               req_ready,
  input logic [`N_BANKS-1:0]                bank_req_valid,
  input logic [`N_BANKS-1:0]                bank_credit,
  input logic [`N_BANKS-1:0]                bank_rsp_pop,
  input logic                               rsp_valid,
  input logic                               rsp_credit
);

  localparam int LVL_W = $clog2(`QUEUE_DEPTH + 1) + 1;  // One spare bit so an overflow shows
  localparam int CR_W  = $clog2(`RSP_CREDITS + 1) + 1;

  logic [LVL_W-1:0] req_lvl [`N_BANKS];  // Shadow fill level of each request queue
  logic [LVL_W-1:0] rsp_lvl [`N_BANKS];  // Shadow fill level of each response queue
  logic [CR_W-1:0]  credits;             // Host credits the collector has not spent
  int               fail_count;          // Assertion failures so far

  //////////////////////////////////////////////////
  // Shadow counters

  // A bank pop moves one entry from its request queue into its response queue
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `N_BANKS; i++) begin
        req_lvl[i] <= '0;
        rsp_lvl[i] <= '0;
      end
      credits <= CR_W'(`RSP_CREDITS);
    end else begin
      for (int i = 0; i < `N_BANKS; i++) begin
        req_lvl[i] <= req_lvl[i] + LVL_W'(bank_req_valid[i]) - LVL_W'(bank_credit[i]);
        rsp_lvl[i] <= rsp_lvl[i] + LVL_W'(bank_credit[i]) - LVL_W'(bank_rsp_pop[i]);
      end
      credits <= credits + CR_W'(rsp_credit) - CR_W'(rsp_valid);
    end
  end

  //////////////////////////////////////////////////
  // Per-bank queue checks

  // Ready has to follow the free slots the shadow level leaves in the named bank
  a_push_credit: assert property (@(posedge clk) disable iff (rst)
    req_ready == (req_lvl[req_bank] < LVL_W'(`QUEUE_DEPTH)))
    else begin
      $error("req_ready disagrees with the credit of bank %0d", req_bank);
      fail_count++;
    end

  for (genvar i = 0; i < `N_BANKS; i++) begin : g_bank_chk
    a_req_overflow: assert property (@(posedge clk) disable iff (rst)
      bank_req_valid[i] |-> (req_lvl[i] < LVL_W'(`QUEUE_DEPTH)))
      else begin
        $error("Bank %0d request queue overflow", i);
        fail_count++;
      end
    a_req_underflow: assert property (@(posedge clk) disable iff (rst)
      bank_credit[i] |-> (req_lvl[i] != '0))
      else begin
        $error("Bank %0d popped an empty queue", i);
        fail_count++;
      end
    a_rsp_overflow: assert property (@(posedge clk) disable iff (rst)
      bank_credit[i] |-> (rsp_lvl[i] < LVL_W'(`QUEUE_DEPTH)))
      else begin
        $error("Bank %0d response queue overflow", i);
        fail_count++;
      end
    a_rsp_underflow: assert property (@(posedge clk) disable iff (rst)
      bank_rsp_pop[i] |-> (rsp_lvl[i] != '0))
      else begin
        $error("Bank %0d response queue underflow", i);
        fail_count++;
      end
  end

  // The response on rsp is charged one cycle late, so it still counts here
  a_rsp_credit: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |-> (credits != '0))
    else begin
      $error("Response issued with no host credit");
      fail_count++;
    end

  a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(bank_rsp_pop))
    else begin
      $error("Collector popped more than one bank");
      fail_count++;
    end

endmodule

bind banked_cache banked_cache_assertions u_assert (
  .clk            (clk),
  .rst            (rst),
  .req_bank       (req.addr.bank),
  .req_ready      (req_ready),
  .bank_req_valid (bank_req_valid),
  .bank_credit    (bank_credit),
  .bank_rsp_pop   (bank_rsp_pop),
  .rsp_valid      (rsp_valid),
  .rsp_credit     (rsp_credit)
);

//--- test/banked_cache_tb.sv
`timescale 1ns/100ps
`include "cache_defines.svh"

module banked_cache_tb;

  import cache_geom_pkg::*;
  import cache_msg_pkg::*;

  localparam int PERIOD     = 100;
  localparam int TOTAL_REQS = 235;  // Requests issued over all six tests
  localparam int BURST_LEN  = 10;

  logic       clk;
  logic       rst;
  cache_req_t req;
  logic       req_valid;
  logic       rsp_credit;
  logic       req_ready;
  cache_rsp_t rsp;
  logic       rsp_valid;

  // Reference model of every bank, the victim way per set starts at 1
  logic [TAG_W-1:0]   m_tag    [`N_BANKS][N_SETS][2];
  bit                 m_valid  [`N_BANKS][N_SETS][2];
  int                 m_victim [`N_BANKS][N_SETS];
  logic [`DATA_W-1:0] m_data   [`N_BANKS][N_SETS][2][N_WORDS];
  bit                 m_known  [`N_BANKS][N_SETS][2][N_WORDS];  // Word written since install

  cache_rsp_t exp_rsp [16];      // Expected response per id
  bit         exp_pending [16];  // Id is waiting for its response
  logic [3:0] next_id;
  logic [3:0] issued_ids [$];
  logic [3:0] rx_ids [$];        // Ids in arrival order
  int         outstanding;
  int         credit_owed;       // Responses seen but not yet credited back
  bit         hold_credit;
  bit         stall_seen;
  int         accepts;
  int         accepts_at_stall;
  int         errors;
  int         checks;
  int         tests_run;
  int         err_at_start;
  int         chk_at_start;
  string      test_name;

  banked_cache DUT (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .req_valid  (req_valid),
    .rsp_credit (rsp_credit),
    .req_ready  (req_ready),
    .rsp        (rsp),
    .rsp_valid  (rsp_valid)
  );

  always #(PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Checks and reference model

  task automatic check_eq(input string what, input int expv, input int actv);
    checks++;
    assert (expv == actv) else begin
      $display("FAIL %s %s: expected %0h actual %0h", test_name, what, expv, actv);
      errors++;
    end
  endtask

  function automatic cache_addr_t make_addr(int tag_i, int set_i, int bank_i, int word_i);
    cache_addr_t a;
    a.tag      = TAG_W'(tag_i);
    a.set      = SET_W'(set_i);
    a.bank     = BANK_W'(bank_i);
    a.word     = WORD_W'(word_i);
    a.byte_sel = 1'b0;
    return a;
  endfunction

  function automatic int find_way(cache_addr_t a);
    int way;
    way = -1;  // No valid way holds the tag
    for (int k = 0; k < 2; k++) begin
      if (m_valid[a.bank][a.set][k] && m_tag[a.bank][a.set][k] == a.tag) way = k;
    end
    return way;
  endfunction

  // A miss reads back zero, a hit is safe only on a word written since install
  function automatic bit read_is_known(cache_addr_t a);
    int way;
    way = find_way(a);
    return (way < 0) || m_known[a.bank][a.set][way][a.word];
  endfunction

  function automatic cache_rsp_t predict(cache_req_t r);
    cache_rsp_t e;
    int b;
    int s;
    int way;
    b       = int'(r.addr.bank);
    s       = int'(r.addr.set);
    way     = find_way(r.addr);
    e       = '0;
    e.write = r.write;
    e.id    = r.id;
    e.hit   = (way >= 0);
    if (way < 0 && r.write) begin  // Install into the victim way
      way                = m_victim[b][s];
      m_tag[b][s][way]   = r.addr.tag;
      m_valid[b][s][way] = 1'b1;
      for (int k = 0; k < N_WORDS; k++) m_known[b][s][way][k] = 1'b0;  // Rest of line is stale
    end
    if (way >= 0) begin
      if (r.write) begin
        m_data[b][s][way][r.addr.word]  = r.data;
        m_known[b][s][way][r.addr.word] = 1'b1;
      end else begin
        e.data = m_data[b][s][way][r.addr.word];
      end
      m_victim[b][s] = 1 - way;  // The other way goes next
    end
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Host model

  // Called 10 ns after an edge, returns at the same point after acceptance
  task automatic send(input logic wr, input cache_addr_t a, input logic [`DATA_W-1:0] d);
    cache_req_t r;
    logic       ok;
    while (exp_pending[next_id]) begin  // Id still in flight
      @(posedge clk);
      #10;
    end
    r.write              = wr;
    r.id                 = next_id;
    r.addr               = a;
    r.data               = d;
    exp_rsp[next_id]     = predict(r);
    exp_pending[next_id] = 1'b1;
    outstanding++;
    issued_ids.push_back(next_id);
    next_id++;
    req       = r;
    req_valid = 1'b1;
    ok        = 1'b0;
    while (!ok) begin
      @(negedge clk);
      ok = req_ready;  // Value holds until the edge
      @(posedge clk);
      #10;
    end
    req_valid = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!rst && req_valid && req_ready) accepts++;
    if (!rst && req_valid && !req_ready && !stall_seen) begin
      stall_seen       = 1'b1;
      accepts_at_stall = accepts;
    end
    if (!rst && rsp_valid) begin
      checks++;
      assert (exp_pending[rsp.id]) else begin
        $display("FAIL %s: response id %0d arrived with no request waiting", test_name, rsp.id);
        errors++;
      end
      if (exp_pending[rsp.id]) begin
        check_eq($sformatf("response id %0d", rsp.id), int'(exp_rsp[rsp.id]), int'(rsp));
        exp_pending[rsp.id] = 1'b0;
        outstanding--;
      end
      rx_ids.push_back(rsp.id);
      credit_owed++;
    end
  end

  // One credit pulse per response, one cycle after it, unless held back
  always @(posedge clk) begin
    #10;
    if (!hold_credit && credit_owed > 0) begin
      rsp_credit = 1'b1;
      credit_owed--;
    end else begin
      rsp_credit = 1'b0;
    end
  end

  task automatic wait_idle();
    while (outstanding != 0 || credit_owed != 0) @(negedge clk);
    @(posedge clk);
    #10;
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = errors;
    chk_at_start = checks;
    issued_ids.delete();
    rx_ids.delete();
  endtask

  task automatic finish_test();
    wait_idle();
    tests_run++;
    $display("%-10s done: %0d checks, %0d errors", test_name, checks - chk_at_start,
             errors - err_at_start);
  endtask

  //////////////////////////////////////////////////
  // Tests

  initial begin : main
    cache_addr_t a;
    logic        wr;
    void'($urandom(32'hfe17));
    clk         = 1'b0;
    rst         = 1'b1;
    req         = '0;
    req_valid   = 1'b0;
    rsp_credit  = 1'b0;
    hold_credit = 1'b0;
    stall_seen  = 1'b0;
    next_id     = '0;
    test_name   = "reset";
    for (int b = 0; b < `N_BANKS; b++) begin
      for (int s = 0; s < N_SETS; s++) begin
        m_victim[b][s] = 1;
        for (int w = 0; w < 2; w++) m_valid[b][s][w] = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    start_test("reset");
    @(negedge clk);
    check_eq("rsp_valid", 0, int'(rsp_valid));
    check_eq("req_ready", 1, int'(req_ready));
    @(posedge clk);
    #10;
    for (int b = 0; b < `N_BANKS; b++) send(1'b0, make_addr(0, 0, b, 0), '0);
    finish_test();

    start_test("write_read");
    for (int b = 0; b < `N_BANKS; b++) begin
      send(1'b1, make_addr(1, 2, b, 3), 16'($urandom));
      send(1'b0, make_addr(1, 2, b, 3), '0);
    end
    finish_test();

    // Tags 3, 4 and 5 share set 5 of bank 1
    start_test("lru");
    send(1'b1, make_addr(3, 5, 1, 2), 16'h3a3a);
    send(1'b1, make_addr(4, 5, 1, 2), 16'h4b4b);
    send(1'b0, make_addr(3, 5, 1, 2), '0);
    send(1'b1, make_addr(5, 5, 1, 2), 16'h5c5c);  // Evicts tag 4
    send(1'b0, make_addr(4, 5, 1, 2), '0);
    send(1'b0, make_addr(3, 5, 1, 2), '0);
    send(1'b0, make_addr(5, 5, 1, 2), '0);
    finish_test();

    // Held credits let both queues and the host credits fill before the stall
    start_test("burst");
    hold_credit = 1'b1;
    stall_seen  = 1'b0;
    accepts     = 0;
    fork
      for (int i = 0; i < BURST_LEN; i++) send(1'b0, make_addr(0, i, 2, 0), '0);
      begin
        while (!stall_seen) @(posedge clk);
        #10;
        hold_credit = 1'b0;
      end
    join
    wait_idle();
    check_eq("accepts before stall", 2 * `QUEUE_DEPTH + `RSP_CREDITS, accepts_at_stall);
    check_eq("responses in burst", issued_ids.size(), rx_ids.size());
    foreach (issued_ids[k]) begin
      if (k < rx_ids.size()) check_eq($sformatf("order %0d", k), issued_ids[k], rx_ids[k]);
    end
    @(negedge clk);
    check_eq("req_ready after burst", 1, int'(req_ready));
    @(posedge clk);
    #10;
    finish_test();

    start_test("credits");
    hold_credit = 1'b1;
    for (int i = 0; i < 6; i++) send(1'b0, make_addr(7, 9, i % `N_BANKS, 0), '0);
    repeat (20) @(posedge clk);
    #10;
    check_eq("responses while held", `RSP_CREDITS, rx_ids.size());
    hold_credit = 1'b0;
    finish_test();

    // Few tags and sets so that hits and evictions are common
    start_test("random");
    for (int n = 0; n < 200; n++) begin
      a  = make_addr($urandom_range(3, 0), $urandom_range(3, 0), $urandom_range(3, 0),
                     $urandom_range(7, 0));
      wr = 1'($urandom_range(1, 0));
      if (!wr && !read_is_known(a)) wr = 1'b1;
      send(wr, a, 16'($urandom));
    end
    finish_test();

    errors += DUT.u_assert.fail_count;
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TOTAL_REQS * 20 * PERIOD);
    $display("Timeout in test %s with %0d responses outstanding", test_name, outstanding);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- banked_cache.f
+incdir+hw
hw/cache_geom_pkg.sv
hw/cache_msg_pkg.sv
hw/credit_fifo.sv
hw/request_dispatcher.sv
hw/cache_bank.sv
hw/response_collector.sv
hw/banked_cache.sv
test/banked_cache_assertions.sv
test/banked_cache_tb.sv

//--- Makefile
TOP := banked_cache_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f banked_cache.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
